//--- design/mt_cpu_pkg.sv
`default_nettype none

package mt_cpu_pkg;

  typedef logic [9:0]  addr_t;     // logical or physical word address
  typedef logic [15:0] word_t;     // data and instruction word
  typedef logic [2:0]  reg_idx_t;  // register number

  typedef enum logic [7:0] {
    op_jmp       = 8'd1,
    op_ram2reg   = 8'd2,
    op_reg2ram   = 8'd3,
    op_num2reg   = 8'd4,
    op_reg_plus  = 8'd5,
    op_reg_minus = 8'd6
  } opcode_t;

  localparam int num_regs = 8;
  localparam int quantum  = 4;                     // instructions per time slice
  localparam int cnt_w    = $clog2(quantum + 1);

  typedef logic [cnt_w-1:0] count_t;  // executed instructions in the slice

  // context area, word offsets from the process base
  localparam addr_t ctx_next_ofs = 10'd0;   // base of the next process
  localparam addr_t ctx_pc_ofs   = 10'd4;   // saved logical pc
  localparam addr_t ctx_reg_ofs  = 10'd14;  // saved r0 .. r7
  localparam addr_t prog_ofs     = 10'd46;  // first pc after reset

  typedef struct packed {
    addr_t addr;
    word_t data;
  } load_t;

  typedef struct packed {
    addr_t base;  // process base
    addr_t addr;  // logical address
    word_t data;
  } store_t;

  typedef struct packed {
    addr_t addr;
    word_t data;
  } mem_wr_t;

  typedef enum logic [2:0] {
    idle, fetch0, fetch1, decode, load_wait, store_hold, switching
  } seq_state_t;

  typedef enum logic [2:0] {
    sw_idle, save_pc, save_regs, read_next, read_pc, read_regs, done
  } sw_state_t;

endpackage

`default_nettype wire

//--- design/dual_port_ram.sv
`default_nettype none

module dual_port_ram (
  input  wire logic                clka,
  input  wire mt_cpu_pkg::mem_wr_t wr,
  input  wire logic                we,
  input  wire mt_cpu_pkg::addr_t   rd_addr,
  output mt_cpu_pkg::word_t        rd_data
);

  // one word per address value
  mt_cpu_pkg::word_t mem [2**$bits(mt_cpu_pkg::addr_t)];

  always_ff @(posedge clka) begin
    if (we) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // registered read, same-address write shows up a cycle later
  always_ff @(posedge clka) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

//--- design/reg_file.sv
`default_nettype none

module reg_file (
  input  wire logic                 clka,
  input  wire logic                 rst,
  input  wire mt_cpu_pkg::reg_idx_t rd_idx,
  output mt_cpu_pkg::word_t         rd_data,
  input  wire mt_cpu_pkg::reg_idx_t wr_idx,
  input  wire mt_cpu_pkg::word_t    wr_data,
  input  wire logic                 we,
  input  wire mt_cpu_pkg::reg_idx_t xfer_idx,
  output mt_cpu_pkg::word_t         xfer_rd_data,
  input  wire mt_cpu_pkg::word_t    xfer_wr_data,
  input  wire logic                 xfer_we
);

  mt_cpu_pkg::word_t regs [mt_cpu_pkg::num_regs];

  always_ff @(posedge clka) begin
    if (!rst) begin
      for (int i = 0; i < mt_cpu_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wr_idx] <= wr_data;         // execute write
    end else if (xfer_we) begin
      regs[xfer_idx] <= xfer_wr_data;  // context restore
    end
  end

  assign rd_data      = regs[rd_idx];
  assign xfer_rd_data = regs[xfer_idx];  // context save

endmodule

`default_nettype wire

//--- design/task_switcher.sv
`default_nettype none

module task_switcher (
  input  wire logic                 clka,
  input  wire logic                 rst,
  input  wire logic                 start,
  input  wire mt_cpu_pkg::addr_t    base,
  input  wire mt_cpu_pkg::addr_t    pc,
  output logic                      done,
  output mt_cpu_pkg::addr_t         new_base,
  output mt_cpu_pkg::addr_t         new_pc,
  output mt_cpu_pkg::mem_wr_t       mem_wr,
  output logic                      mem_we,
  output mt_cpu_pkg::addr_t         rd_addr,
  input  wire mt_cpu_pkg::word_t    rd_data,
  output mt_cpu_pkg::reg_idx_t      xfer_idx,
  input  wire mt_cpu_pkg::word_t    xfer_rd_data,
  output mt_cpu_pkg::word_t         xfer_wr_data,
  output logic                      xfer_we
);

  mt_cpu_pkg::sw_state_t state;
  mt_cpu_pkg::reg_idx_t  idx;     // register index, also the read_next phase
  logic                  idx_last;

  assign idx_last = (idx == mt_cpu_pkg::reg_idx_t'(mt_cpu_pkg::num_regs - 1));

  // sw_start 1, save 1+8, next base 2, pc 1, regs 8, done on cycle 21
  always_ff @(posedge clka) begin
    if (!rst) begin
      state <= mt_cpu_pkg::sw_idle;
      idx   <= '0;
    end else begin
      case (state)
        mt_cpu_pkg::sw_idle: if (start) begin
          idx   <= '0;
          state <= mt_cpu_pkg::save_pc;
        end
        mt_cpu_pkg::save_pc: state <= mt_cpu_pkg::save_regs;
        mt_cpu_pkg::save_regs: begin
          idx <= idx + 1'b1;
          if (idx_last) state <= mt_cpu_pkg::read_next;  // idx wraps to 0
        end
        mt_cpu_pkg::read_next: begin
          if (idx[0]) begin
            idx   <= '0;
            state <= mt_cpu_pkg::read_pc;
          end else begin
            idx <= idx + 1'b1;
          end
        end
        mt_cpu_pkg::read_pc: state <= mt_cpu_pkg::read_regs;
        mt_cpu_pkg::read_regs: begin
          idx <= idx + 1'b1;
          if (idx_last) state <= mt_cpu_pkg::done;
        end
        default: state <= mt_cpu_pkg::sw_idle;  // done lasts one cycle
      endcase
    end
  end

  always_ff @(posedge clka) begin
    if (state == mt_cpu_pkg::read_next && idx[0]) begin
      new_base <= rd_data[$bits(mt_cpu_pkg::addr_t)-1:0];
    end
    if (state == mt_cpu_pkg::read_pc) begin
      new_pc <= rd_data[$bits(mt_cpu_pkg::addr_t)-1:0];
    end
  end

  // save side writes the old context
  always_comb begin
    mem_we = 1'b0;
    mem_wr = '{addr: base + mt_cpu_pkg::ctx_pc_ofs, data: mt_cpu_pkg::word_t'(pc)};
    case (state)
      mt_cpu_pkg::save_pc: mem_we = 1'b1;
      mt_cpu_pkg::save_regs: begin
        mem_we = 1'b1;
        mem_wr = '{addr: base + mt_cpu_pkg::ctx_reg_ofs + mt_cpu_pkg::addr_t'(idx),
                   data: xfer_rd_data};
      end
      default: ;
    endcase
  end

  // read address runs one word ahead of the captured data
  always_comb begin
    rd_addr = base + mt_cpu_pkg::ctx_next_ofs;
    case (state)
      mt_cpu_pkg::read_next: if (idx[0]) begin
        rd_addr = rd_data[$bits(mt_cpu_pkg::addr_t)-1:0] + mt_cpu_pkg::ctx_pc_ofs;
      end
      mt_cpu_pkg::read_pc: rd_addr = new_base + mt_cpu_pkg::ctx_reg_ofs;
      mt_cpu_pkg::read_regs: begin
        rd_addr = new_base + mt_cpu_pkg::ctx_reg_ofs + mt_cpu_pkg::addr_t'(idx) + 10'd1;
      end
      default: ;
    endcase
  end

  assign xfer_idx     = idx;
  assign xfer_wr_data = rd_data;
  assign xfer_we      = (state == mt_cpu_pkg::read_regs);
  assign done         = (state == mt_cpu_pkg::done);

endmodule

`default_nettype wire

//--- design/cpu_sequencer.sv
`default_nettype none

module cpu_sequencer (
  input  wire logic                 clka,
  input  wire logic                 rst,
  input  wire logic                 go,
  input  wire mt_cpu_pkg::load_t    load,
  input  wire logic                 load_valid,
  output logic                      load_ready,
  output mt_cpu_pkg::store_t        store,
  output logic                      store_valid,
  input  wire logic                 store_ready,
  output mt_cpu_pkg::mem_wr_t       mem_wr,
  output logic                      mem_we,
  output mt_cpu_pkg::addr_t         rd_addr,
  input  wire mt_cpu_pkg::word_t    rd_data,
  output mt_cpu_pkg::reg_idx_t      rf_rd_idx,
  input  wire mt_cpu_pkg::word_t    rf_rd_data,
  output mt_cpu_pkg::reg_idx_t      rf_wr_idx,
  output mt_cpu_pkg::word_t         rf_wr_data,
  output logic                      rf_we,
  output logic                      sw_start,
  output mt_cpu_pkg::addr_t         sw_base,
  output mt_cpu_pkg::addr_t         sw_pc,
  input  wire logic                 sw_done,
  input  wire mt_cpu_pkg::addr_t    sw_new_base,
  input  wire mt_cpu_pkg::addr_t    sw_new_pc,
  input  wire mt_cpu_pkg::mem_wr_t  sw_wr,
  input  wire logic                 sw_we,
  input  wire mt_cpu_pkg::addr_t    sw_rd_addr
);

  mt_cpu_pkg::seq_state_t state;
  mt_cpu_pkg::addr_t      base;        // current process base
  mt_cpu_pkg::addr_t      pc;          // logical pc
  mt_cpu_pkg::count_t     icount;
  logic                   phase;       // address cycle / data cycle
  logic                   sw_start_r;
  mt_cpu_pkg::word_t      ir0, ir1;    // instruction words
  mt_cpu_pkg::store_t     store_r;
  mt_cpu_pkg::opcode_t    op;
  mt_cpu_pkg::addr_t      opnd_addr;
  logic                   instr_done;
  logic                   slice_end;

  assign op        = mt_cpu_pkg::opcode_t'(ir0[15:8]);
  assign opnd_addr = ir1[$bits(mt_cpu_pkg::addr_t)-1:0];
  assign rf_rd_idx = ir0[$bits(mt_cpu_pkg::reg_idx_t)-1:0];
  assign slice_end = (icount == mt_cpu_pkg::count_t'(mt_cpu_pkg::quantum - 1));

  always_comb begin
    case (state)
      mt_cpu_pkg::decode:
        instr_done = !(op == mt_cpu_pkg::op_ram2reg || op == mt_cpu_pkg::op_reg2ram);
      mt_cpu_pkg::load_wait:  instr_done = phase;
      mt_cpu_pkg::store_hold: instr_done = store_ready;
      default:                instr_done = 1'b0;
    endcase
  end

  always_ff @(posedge clka) begin
    if (!rst) begin
      state      <= mt_cpu_pkg::idle;
      base       <= '0;
      pc         <= mt_cpu_pkg::prog_ofs;
      icount     <= '0;
      phase      <= 1'b0;
      sw_start_r <= 1'b0;
    end else begin
      sw_start_r <= 1'b0;
      case (state)
        mt_cpu_pkg::idle: if (go) state <= mt_cpu_pkg::fetch0;
        mt_cpu_pkg::fetch0, mt_cpu_pkg::fetch1: begin
          phase <= !phase;
          if (phase) begin
            pc    <= pc + 10'd1;
            state <= (state == mt_cpu_pkg::fetch0) ? mt_cpu_pkg::fetch1 : mt_cpu_pkg::decode;
          end
        end
        mt_cpu_pkg::decode: begin
          if (op == mt_cpu_pkg::op_jmp) pc <= opnd_addr;
          if (op == mt_cpu_pkg::op_ram2reg) state <= mt_cpu_pkg::load_wait;
          if (op == mt_cpu_pkg::op_reg2ram) state <= mt_cpu_pkg::store_hold;
        end
        mt_cpu_pkg::load_wait: phase <= !phase;
        mt_cpu_pkg::switching: if (sw_done) begin
          base   <= sw_new_base;
          pc     <= sw_new_pc;
          icount <= '0;
          state  <= mt_cpu_pkg::fetch0;
        end
        default: ;
      endcase
      if (instr_done) begin
        icount <= icount + 1'b1;
        if (slice_end) begin
          state      <= mt_cpu_pkg::switching;
          sw_start_r <= 1'b1;
        end else begin
          state <= mt_cpu_pkg::fetch0;
        end
      end
    end
  end

  // instruction and store payload
  always_ff @(posedge clka) begin
    if (state == mt_cpu_pkg::fetch0 && phase) ir0 <= rd_data;
    if (state == mt_cpu_pkg::fetch1 && phase) ir1 <= rd_data;
    if (state == mt_cpu_pkg::decode && op == mt_cpu_pkg::op_reg2ram) begin
      store_r <= '{base: base, addr: opnd_addr, data: rf_rd_data};
    end
  end

  // memory port owner
  always_comb begin
    mem_we  = 1'b0;
    mem_wr  = '{addr: load.addr, data: load.data};
    rd_addr = base + pc;  // fetch translation
    case (state)
      mt_cpu_pkg::idle:      mem_we = load_valid;
      mt_cpu_pkg::load_wait: rd_addr = base + opnd_addr;
      mt_cpu_pkg::store_hold: begin
        mem_we = store_ready;
        mem_wr = '{addr: store_r.base + store_r.addr, data: store_r.data};
      end
      mt_cpu_pkg::switching: begin
        mem_we  = sw_we;
        mem_wr  = sw_wr;
        rd_addr = sw_rd_addr;
      end
      default: ;
    endcase
  end

  always_comb begin
    rf_we      = 1'b0;
    rf_wr_idx  = rf_rd_idx;
    rf_wr_data = ir1;  // load immediate
    if (state == mt_cpu_pkg::decode) begin
      case (op)
        mt_cpu_pkg::op_num2reg:   rf_we = 1'b1;
        mt_cpu_pkg::op_reg_plus: begin
          rf_we      = 1'b1;
          rf_wr_data = rf_rd_data + ir1;
        end
        mt_cpu_pkg::op_reg_minus: begin
          rf_we      = 1'b1;
          rf_wr_data = rf_rd_data - ir1;
        end
        default: ;  // other opcodes are no-ops
      endcase
    end else if (state == mt_cpu_pkg::load_wait && phase) begin
      rf_we      = 1'b1;
      rf_wr_data = rd_data;
    end
  end

  assign load_ready  = (state == mt_cpu_pkg::idle);
  assign store_valid = (state == mt_cpu_pkg::store_hold);
  assign store       = store_r;
  assign sw_start    = sw_start_r;
  assign sw_base     = base;
  assign sw_pc       = pc;

endmodule

`default_nettype wire

//--- design/mt_cpu.sv
`default_nettype none

module mt_cpu (
  input  wire logic              clka,
  input  wire logic              rst,
  input  wire logic              go,
  input  wire mt_cpu_pkg::load_t load,
  input  wire logic              load_valid,
  output logic                   load_ready,
  output mt_cpu_pkg::store_t     store,
  output logic                   store_valid,
  input  wire logic              store_ready
);

  mt_cpu_pkg::mem_wr_t  mem_wr;
  logic                 mem_we;
  mt_cpu_pkg::addr_t    rd_addr;
  mt_cpu_pkg::word_t    rd_data;

  mt_cpu_pkg::reg_idx_t rf_rd_idx, rf_wr_idx;
  mt_cpu_pkg::word_t    rf_rd_data, rf_wr_data;
  logic                 rf_we;

  logic                 sw_start, sw_done;
  mt_cpu_pkg::addr_t    sw_base, sw_pc, sw_new_base, sw_new_pc;
  mt_cpu_pkg::mem_wr_t  sw_wr;
  logic                 sw_we;
  mt_cpu_pkg::addr_t    sw_rd_addr;

  mt_cpu_pkg::reg_idx_t xfer_idx;
  mt_cpu_pkg::word_t    xfer_rd_data, xfer_wr_data;
  logic                 xfer_we;

  cpu_sequencer u_seq (
    .clka        (clka),        .rst         (rst),         .go          (go),
    .load        (load),        .load_valid  (load_valid),  .load_ready  (load_ready),
    .store       (store),       .store_valid (store_valid), .store_ready (store_ready),
    .mem_wr      (mem_wr),      .mem_we      (mem_we),
    .rd_addr     (rd_addr),     .rd_data     (rd_data),
    .rf_rd_idx   (rf_rd_idx),   .rf_rd_data  (rf_rd_data),
    .rf_wr_idx   (rf_wr_idx),   .rf_wr_data  (rf_wr_data),  .rf_we       (rf_we),
    .sw_start    (sw_start),    .sw_base     (sw_base),     .sw_pc       (sw_pc),
    .sw_done     (sw_done),     .sw_new_base (sw_new_base), .sw_new_pc   (sw_new_pc),
    .sw_wr       (sw_wr),       .sw_we       (sw_we),       .sw_rd_addr  (sw_rd_addr)
  );

  reg_file u_regs (
    .clka         (clka),
    .rst          (rst),
    .rd_idx       (rf_rd_idx),
    .rd_data      (rf_rd_data),
    .wr_idx       (rf_wr_idx),
    .wr_data      (rf_wr_data),
    .we           (rf_we),
    .xfer_idx     (xfer_idx),
    .xfer_rd_data (xfer_rd_data),
    .xfer_wr_data (xfer_wr_data),
    .xfer_we      (xfer_we)
  );

  task_switcher u_switch (
    .clka         (clka),        .rst          (rst),
    .start        (sw_start),    .base         (sw_base),      .pc      (sw_pc),
    .done         (sw_done),     .new_base     (sw_new_base),  .new_pc  (sw_new_pc),
    .mem_wr       (sw_wr),       .mem_we       (sw_we),
    .rd_addr      (sw_rd_addr),  .rd_data      (rd_data),
    .xfer_idx     (xfer_idx),    .xfer_rd_data (xfer_rd_data),
    .xfer_wr_data (xfer_wr_data), .xfer_we     (xfer_we)
  );

  dual_port_ram u_ram (
    .clka    (clka),
    .wr      (mem_wr),
    .we      (mem_we),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

`default_nettype wire

//--- verif/mt_cpu_assert.sv
`default_nettype none

module mt_cpu_assert (
  input wire logic               clka,
  input wire logic               rst,
  input wire logic               go,
  input wire logic               load_ready,
  input wire mt_cpu_pkg::store_t store,
  input wire logic               store_valid,
  input wire logic               store_ready
);

  timeunit 1ns;
  timeprecision 100ps;

  int hold_fails, reset_fails, leave_fails, stay_fails;
  int failures;  // read by the testbench

  assign failures = hold_fails + reset_fails + leave_fails + stay_fails;

  // payload frozen while the host stalls
  store_hold: assert property (@(posedge clka) disable iff (!rst)
    store_valid && !store_ready |=> store_valid && $stable(store))
    else begin $error("store changed while store_ready was low"); hold_fails++; end

  store_reset: assert property (@(posedge clka) !rst |=> !store_valid)
    else begin $error("store_valid high after a reset edge"); reset_fails++; end

  // go ends the load phase for good
  idle_leave: assert property (@(posedge clka) disable iff (!rst) go |=> !load_ready)
    else begin $error("load_ready still high after go"); leave_fails++; end

  idle_stay: assert property (@(posedge clka) disable iff (!rst) !load_ready |=> !load_ready)
    else begin $error("core went back to idle"); stay_fails++; end

endmodule

`default_nettype wire

//--- verif/mt_cpu_checker.sv
`default_nettype none

module mt_cpu_checker (
  input  wire logic               clka,
  input  wire logic               rst,
  input  wire mt_cpu_pkg::store_t store,
  input  wire logic               store_valid,
  input  wire logic               store_ready,
  output logic                    done,
  output int                      error_count,
  output int                      store_count
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int per_proc = 12;  // stores checked for each process

  mt_cpu_pkg::store_t expected [2][per_proc];  // [0] base 0, [1] base 200
  int                 seen [2];

  initial begin
    for (int n = 0; n < per_proc; n++) begin
      // process a alternates +3 then -1
      expected[0][n] = '{base: 10'd0, addr: 10'd100 + 10'(n % 2),
                         data: 16'((n % 2 == 0) ? 8 + n : 6 + n)};
      // process b climbs by one every second store
      expected[1][n] = '{base: 10'd200, addr: 10'd100, data: 16'((n + 1) / 2 + 1)};
    end
  end

  always @(posedge clka) begin
    int p;
    mt_cpu_pkg::store_t want;
    if (!rst) begin
      seen[0]     <= 0;
      seen[1]     <= 0;
      error_count <= 0;
      store_count <= 0;
    end else if (store_valid && store_ready) begin  // one transfer per edge
      p = (store.base == 10'd200) ? 1 : 0;
      want = expected[p][seen[p] % per_proc];
      store_count <= store_count + 1;
      if (store.base != 10'd0 && store.base != 10'd200) begin
        error_count <= error_count + 1;
        $display("error %0t: store from unknown base %0d", $time, store.base);
      end else if (seen[p] < per_proc) begin
        seen[p] <= seen[p] + 1;
        if (store !== want) begin
          error_count <= error_count + 1;
          $display("error %0t: base %0d store %0d got addr %0d data %0d, expected %0d %0d",
                   $time, store.base, seen[p], store.addr, store.data, want.addr, want.data);
        end
      end
    end
  end

  assign done = (seen[0] >= per_proc) && (seen[1] >= per_proc);

endmodule

`default_nettype wire

//--- verif/tb_mt_cpu.sv
`default_nettype none

module tb_mt_cpu;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int image_len = 37;

  // address, data
  localparam mt_cpu_pkg::load_t image [image_len] = '{
    '{10'd0,   16'd200},                        // a: next process
    '{10'd200, 16'd0},    '{10'd204, 16'd46},   // b: next process, saved pc
    '{10'd214, 16'd0},    '{10'd215, 16'd0},    '{10'd216, 16'd0},    '{10'd217, 16'd0},
    '{10'd218, 16'd0},    '{10'd219, 16'd0},    '{10'd220, 16'd0},    '{10'd221, 16'd0},
    '{10'd46,  16'h0401}, '{10'd47,  16'd5},    // r1 = 5
    '{10'd48,  16'h0501}, '{10'd49,  16'd3},    // r1 += 3
    '{10'd50,  16'h0301}, '{10'd51,  16'd100},  // [100] = r1
    '{10'd52,  16'h0601}, '{10'd53,  16'd1},    // r1 -= 1
    '{10'd54,  16'h0301}, '{10'd55,  16'd101},  // [101] = r1
    '{10'd56,  16'h0100}, '{10'd57,  16'd48},
    '{10'd246, 16'h0402}, '{10'd247, 16'd1},    // r2 = 1
    '{10'd248, 16'h0302}, '{10'd249, 16'd100},  // [100] = r2
    '{10'd250, 16'h0203}, '{10'd251, 16'd100},  // r3 = [100]
    '{10'd252, 16'h0503}, '{10'd253, 16'd1},
    '{10'd254, 16'h0303}, '{10'd255, 16'd100},
    '{10'd256, 16'h0202}, '{10'd257, 16'd100},  // r2 = [100]
    '{10'd258, 16'h0100}, '{10'd259, 16'd48}
  };

  logic               clka, rst, go, load_valid, load_ready, store_valid, store_ready;
  mt_cpu_pkg::load_t  load;
  mt_cpu_pkg::store_t store;
  logic               check_done;
  int                 mismatches, stores_seen;
  logic [15:0]        lfsr;

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  mt_cpu dut0 (.*);

  mt_cpu_checker check0 (
    .clka, .rst, .store, .store_valid, .store_ready,
    .done (check_done), .error_count (mismatches), .store_count (stores_seen)
  );

  bind mt_cpu mt_cpu_assert asserts0 (
    .clka, .rst, .go, .load_ready, .store, .store_valid, .store_ready
  );

  initial begin
    clka = 1'b0;
    forever #2 clka = ~clka;
  end

  // random back-pressure, one lfsr step per bit
  initial begin
    lfsr        = 16'd54726;
    store_ready = 1'b0;
    forever begin
      @(negedge clka);
      lfsr        = lfsr_step(lfsr);
      store_ready = lfsr[0];
    end
  end

  initial begin
    int   wait_cnt;
    logic load_ok;
    rst        = 1'b0;
    go         = 1'b0;
    load       = '0;
    load_valid = 1'b0;
    load_ok    = 1'b1;
    repeat (5) @(negedge clka);
    rst = 1'b1;
    for (int i = 0; i < image_len && load_ok; i++) begin
      wait_cnt = 0;
      while (!load_ready && wait_cnt < 20) begin
        @(negedge clka);
        wait_cnt++;
      end
      load_ok    = load_ready;
      load       = image[i];
      load_valid = load_ok;
      @(negedge clka);
    end
    load_valid = 1'b0;
    go         = 1'b1;
    wait_cnt   = 0;
    while (!check_done && wait_cnt < 6000) begin
      @(negedge clka);
      wait_cnt++;
    end
    if (!load_ok) $display("load port never became ready");
    if (!check_done) $display("timed out waiting for the expected stores");
    $display("stores %0d, mismatches %0d, assertion failures %0d",
             stores_seen, mismatches, dut0.asserts0.failures);
    if (load_ok && check_done && mismatches == 0 && dut0.asserts0.failures == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- mt_cpu.f
design/mt_cpu_pkg.sv
design/dual_port_ram.sv
design/reg_file.sv
design/task_switcher.sv
design/cpu_sequencer.sv
design/mt_cpu.sv
verif/mt_cpu_assert.sv
verif/mt_cpu_checker.sv
verif/tb_mt_cpu.sv

//--- Makefile
TOOL      = verilator
TOP       = tb_mt_cpu
FILE_LIST = mt_cpu.f
FLAGS     = --binary --timing --assert --timescale 1ns/1ps -j 0
OBJ_DIR   = obj_dir
RUN_ARGS  = +verilator+error+limit+100
PASS_MSG  = Verification passed

SRCS = $(filter-out +%,$(shell cat $(FILE_LIST)))
SIM  = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILE_LIST) $(SRCS)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(SIM)
	@out="$$(./$(SIM) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
